// ==== list.f ====
+incdir+include
logic/alu_op_pkg.sv
logic/alu_result_pkg.sv
logic/alu_dispatch.sv
logic/alu_core.sv
logic/alu_divider.sv
logic/alu_thread_lane.sv
logic/alu_result_merge.sv
logic/alu_cluster_top.sv
tests/alu_ref_pkg.sv
tests/alu_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cluster testbench, the log decides pass or fail
rm -rf obj_dir sim.log
{ verilator --binary --assert --timing --top-module alu_cluster_tb -f list.f -o alu_sim &&
	./obj_dir/alu_sim; } > sim.log 2>&1 || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

// ==== tests/alu_cluster_tb.sv ====
`include "alu_params.svh"

module alu_cluster_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import alu_op_pkg::*;
	import alu_result_pkg::*;
	import alu_ref_pkg::*;

	localparam int SEED    = 91138;
	localparam int TIMEOUT = 200;
	localparam int NT      = `ALU_NUM_THREADS;
	localparam alu_ctl_t SINGLE_OPS [13] = '{CTL_AND, CTL_OR, CTL_XOR, CTL_ADDU, CTL_SUBU,
		CTL_SLT, CTL_SLTU, CTL_SLL, CTL_SRL, CTL_SRA, CTL_SLLV, CTL_SRLV, CTL_SRAV};
	localparam alu_ctl_t MIXED_OPS [10] = '{CTL_ADDU, CTL_XOR, CTL_SRAV, CTL_LUI, CTL_MULT,
		CTL_MULTU, CTL_DIV, CTL_DIVU, CTL_MFHI, CTL_MFLO};

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	alu_word_t  in_instr;
	thread_id_t in_thread;
	alu_word_t  in_rs;
	alu_word_t  in_rt;
	logic [NT-1:0] thread_busy;
	logic       in_reject;
	logic       out_valid;
	thread_id_t out_thread;
	alu_word_t  out_y;
	logic       out_zero;

	lane_result_t exp_q [NT][$];  // Expected results per thread, in issue order
	hilo_t        model_hilo [NT];
	int           value_errors;
	int           other_errors;
	string        test_name;

	alu_cluster_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assert property (@(negedge clk) !rst_n |-> (!out_valid && !in_reject && thread_busy == '0))
	else begin
		$display("Outputs active while reset is asserted");
		other_errors++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> !thread_busy[out_thread])
	else begin
		$display("Thread %0d still busy after its result left", out_thread);
		other_errors++;
	end

	// Scoreboard on stable values
	always @(negedge clk) begin
		int th;
		lane_result_t want;
		if (rst_n && out_valid) begin
			th = int'(out_thread);
			if (exp_q[th].size() == 0) begin
				$display("Unexpected result from thread %0d during %s", th, test_name);
				other_errors++;
			end else begin
				want = exp_q[th].pop_front();
				assert (out_y == want.y)
				else begin
					$display("** Error %s thread %0d y: expected %h actual %h",
						test_name, th, want.y, out_y);
					value_errors++;
				end
				assert (out_zero == want.zero)
				else begin
					$display("** Error %s thread %0d zero: expected %b actual %b",
						test_name, th, want.zero, out_zero);
					value_errors++;
				end
			end
		end
	end

	function automatic alu_word_t encode(alu_ctl_t ctl, logic [15:0] imm);
		logic [5:0] funct;
		case (ctl)
			CTL_BLTZ:   return {6'h01, 5'd1, 5'h00, imm};
			CTL_BLTZAL: return {6'h01, 5'd1, 5'h10, imm};
			CTL_BEQ:    return {6'h04, 5'd1, 5'd0, imm};
			CTL_BNE:    return {6'h05, 5'd1, 5'd0, imm};
			CTL_BGTZ:   return {6'h07, 5'd1, 5'd0, imm};
			CTL_LUI:    return {6'h0f, 5'd0, 5'd1, imm};
			default:    ;
		endcase
		case (ctl)
			CTL_SLL:   funct = 6'h00;
			CTL_SRL:   funct = 6'h02;
			CTL_SRA:   funct = 6'h03;
			CTL_SLLV:  funct = 6'h04;
			CTL_SRLV:  funct = 6'h06;
			CTL_SRAV:  funct = 6'h07;
			CTL_JR:    funct = 6'h08;
			CTL_MFHI:  funct = 6'h10;
			CTL_MFLO:  funct = 6'h12;
			CTL_MULT:  funct = 6'h18;
			CTL_MULTU: funct = 6'h19;
			CTL_DIV:   funct = 6'h1a;
			CTL_DIVU:  funct = 6'h1b;
			CTL_ADDU:  funct = 6'h21;
			CTL_SUBU:  funct = 6'h23;
			CTL_OR:    funct = 6'h25;
			CTL_XOR:   funct = 6'h26;
			CTL_SLT:   funct = 6'h2a;
			CTL_SLTU:  funct = 6'h2b;
			default:   funct = 6'h24;
		endcase
		return {6'h00, 10'd0, imm[15:6], funct};  // rd and sa from imm
	endfunction

	// Thread is free once its last result left and busy dropped
	task automatic wait_idle(input int th);
		int cycles;
		cycles = 0;
		while ((exp_q[th].size() != 0 || thread_busy[th]) && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("Timeout: thread %0d hung in %s", th, test_name);
			other_errors++;
		end
	endtask

	task automatic wait_all_idle();
		for (int t = 0; t < NT; t++)
			wait_idle(t);
	endtask

	task automatic issue(input int th, input alu_ctl_t ctl, input alu_word_t rs,
		input alu_word_t rt, input logic [15:0] imm);
		alu_word_t instr;
		alu_word_t y;
		instr = encode(ctl, imm);
		wait_idle(th);
		y = ref_y(ctl, rs, rt, instr, model_hilo[th]);
		model_hilo[th] = ref_hilo(ctl, rs, rt, model_hilo[th]);
		exp_q[th].push_back('{y: y, zero: (y == '0)});
		in_valid  = 1'b1;
		in_instr  = instr;
		in_thread = thread_id_t'(th);
		in_rs     = rs;
		in_rt     = rt;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic issue_hilo_reads(input int th);
		issue(th, CTL_MFHI, $urandom(), $urandom(), 16'h0);
		issue(th, CTL_MFLO, $urandom(), $urandom(), 16'h0);
	endtask

	initial begin
		int cycles;
		alu_word_t dvd [8];
		alu_word_t dvs [8];
		alu_word_t br_a [3];
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		in_thread = '0;
		in_rs = '0;
		in_rt = '0;
		value_errors = 0;
		other_errors = 0;
		for (int t = 0; t < NT; t++) begin
			model_hilo[t] = '0;
		end

		test_name = "reset";
		for (int i = 0; i < 3; i++) begin
			if (i == 2)
				rst_n = 1'b1;  // Released after two cycles
			@(negedge clk);
			assert (!out_valid && !in_reject && thread_busy == '0)
			else begin
				$display("Outputs not idle around reset");
				other_errors++;
			end
		end
		for (int t = 0; t < NT; t++)
			issue_hilo_reads(t);
		wait_all_idle();

		test_name = "single_cycle";
		issue(0, CTL_ADDU, $urandom(), $urandom(), 16'h0);
		@(negedge clk);
		assert (!out_valid) else begin
			$display("Result came one cycle early");
			other_errors++;
		end
		@(negedge clk);
		assert (out_valid && out_thread == 0) else begin
			$display("Result missing two cycles after issue");
			other_errors++;
		end
		for (int i = 0; i < 40; i++)
			issue(0, SINGLE_OPS[$urandom_range(0, 12)], $urandom(), $urandom(),
				16'($urandom()));
		issue(0, CTL_LUI, $urandom(), $urandom(), 16'($urandom()));
		issue(0, CTL_JR, $urandom(), $urandom(), 16'h0);
		issue(0, CTL_JR, 32'd0, $urandom(), 16'h0);
		wait_all_idle();

		test_name = "mul_div";
		for (int i = 0; i < 4; i++) begin
			issue(2, (i % 2) ? CTL_MULT : CTL_MULTU, $urandom(), $urandom(), 16'h0);
			issue_hilo_reads(2);
		end
		dvd = '{-32'sd7, 32'd7, -32'sd7, 32'd100, -32'sd5, 32'd5, 32'h80000000, $urandom()};
		dvs = '{32'd2, -32'sd2, -32'sd2, 32'd7, 32'd0, 32'd0, 32'hffffffff, $urandom()};
		for (int i = 0; i < 8; i++) begin
			issue(2, CTL_DIV, dvd[i], dvs[i], 16'h0);
			issue_hilo_reads(2);
			issue(2, CTL_DIVU, dvd[i], dvs[i], 16'h0);
			issue_hilo_reads(2);
		end
		wait_all_idle();

		test_name = "branch";
		br_a = '{-32'sd5, 32'd0, 32'd9};
		for (int i = 0; i < 3; i++) begin
			issue(3, CTL_BLTZ, br_a[i], $urandom(), 16'($urandom()));
			issue(3, CTL_BLTZAL, br_a[i], $urandom(), 16'($urandom()));
			issue(3, CTL_BGTZ, br_a[i], $urandom(), 16'($urandom()));
			issue(3, CTL_BEQ, br_a[i], $urandom(), 16'($urandom()));
			issue(3, CTL_BNE, br_a[i], $urandom(), 16'($urandom()));
		end
		wait_all_idle();

		test_name = "busy_reject";
		issue(1, CTL_DIV, 32'd1000, 32'd7, 16'h0);
		@(negedge clk);
		in_valid  = 1'b1;  // Same thread while its divide runs
		in_instr  = encode(CTL_ADDU, 16'h0);
		in_thread = thread_id_t'(1);
		@(negedge clk);
		in_valid = 1'b0;
		assert (in_reject) else begin
			$display("Issue to a busy thread was not rejected");
			other_errors++;
		end
		cycles = 0;
		while (!(out_valid && out_thread == 1) && cycles < TIMEOUT) begin
			assert (thread_busy[1]) else begin
				$display("Thread 1 dropped busy before its divide result");
				other_errors++;
			end
			@(negedge clk);
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("Timeout: thread 1 never returned its divide");
			other_errors++;
		end
		wait_all_idle();

		test_name = "threads";
		for (int i = 0; i < 80; i++)
			issue(i % NT, MIXED_OPS[$urandom_range(0, 9)], $urandom(), $urandom(),
				16'($urandom()));
		for (int t = 0; t < NT; t++)
			issue_hilo_reads(t);
		wait_all_idle();

		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== tests/alu_ref_pkg.sv ====
package alu_ref_pkg;
	import alu_op_pkg::*;
	import alu_result_pkg::*;

	// Expected y of one operation, straight from the instruction set rules
	function automatic alu_word_t ref_y(alu_ctl_t ctl, alu_word_t rs, alu_word_t rt,
		alu_word_t instr, hilo_t hl);
		case (ctl)
			CTL_AND:  return rs & rt;
			CTL_OR:   return rs | rt;
			CTL_XOR:  return rs ^ rt;
			CTL_ADDU: return rs + rt;
			CTL_SUBU: return rs - rt;
			CTL_SLTU: return (rs < rt) ? 32'd1 : 32'd0;
			CTL_SLT:  return ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
			CTL_SLL:  return rs << instr[10:6];
			CTL_SRL:  return rs >> instr[10:6];
			CTL_SRA:  return $signed(rs) >>> instr[10:6];
			CTL_SLLV: return rs << rt[4:0];
			CTL_SRLV: return rs >> rt[4:0];
			CTL_SRAV: return $signed(rs) >>> rt[4:0];
			CTL_MFHI: return hl.hi;
			CTL_MFLO: return hl.lo;
			CTL_BLTZ, CTL_BLTZAL: return ($signed(rs) < 0) ? 32'd0 : 32'd1;  // Zero means taken
			CTL_BGTZ: return ($signed(rs) > 0) ? 32'd0 : 32'd1;
			CTL_BEQ:  return (rs == 32'd0) ? 32'd0 : 32'd1;
			CTL_BNE:  return (rs != 32'd0) ? 32'd0 : 32'd1;
			CTL_LUI:  return {instr[15:0], 16'h0000};
			CTL_JR:   return rs;
			default:  return 32'd0;  // Multiply and divide report via HI/LO
		endcase
	endfunction

	// HI/LO after the operation
	function automatic hilo_t ref_hilo(alu_ctl_t ctl, alu_word_t rs, alu_word_t rt, hilo_t hl);
		longint q;
		longint r;
		case (ctl)
			CTL_MULTU: return hilo_t'(longint'({32'd0, rs}) * longint'({32'd0, rt}));
			CTL_MULT:  return hilo_t'(longint'($signed(rs)) * longint'($signed(rt)));
			CTL_DIV, CTL_DIVU: begin
				if (rt == 32'd0)
					return '{hi: rs, lo: 32'hffffffff};
				if (ctl == CTL_DIV) begin
					q = longint'($signed(rs)) / longint'($signed(rt));  // Truncates toward zero
					r = longint'($signed(rs)) % longint'($signed(rt));
				end else begin
					q = longint'({32'd0, rs}) / longint'({32'd0, rt});
					r = longint'({32'd0, rs}) % longint'({32'd0, rt});
				end
				return '{hi: r[31:0], lo: q[31:0]};
			end
			default: return hl;
		endcase
	endfunction

endpackage

// ==== logic/alu_cluster_top.sv ====
`include "alu_params.svh"

module alu_cluster_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         in_valid,
	input  alu_op_pkg::alu_word_t        in_instr,
	input  alu_op_pkg::thread_id_t       in_thread,
	input  alu_op_pkg::alu_word_t        in_rs,
	input  alu_op_pkg::alu_word_t        in_rt,
	output logic [`ALU_NUM_THREADS-1:0]  thread_busy,
	output logic                         in_reject,
	output logic                         out_valid,
	output alu_op_pkg::thread_id_t       out_thread,
	output alu_op_pkg::alu_word_t        out_y,
	output logic                         out_zero
);
	import alu_op_pkg::*;
	import alu_result_pkg::*;

	logic [`ALU_NUM_THREADS-1:0] issue_valid;
	alu_issue_t                  issue_op;      // Shared by all lanes
	logic [`ALU_NUM_THREADS-1:0] lane_done;
	lane_result_t                lane_result [`ALU_NUM_THREADS];
	logic [`ALU_NUM_THREADS-1:0] take;

	alu_dispatch u_dispatch (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_instr    (in_instr),
		.in_thread   (in_thread),
		.in_rs       (in_rs),
		.in_rt       (in_rt),
		.lane_busy   (thread_busy),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.in_reject   (in_reject)
	);

	for (genvar i = 0; i < `ALU_NUM_THREADS; i++) begin : g_lane
		alu_thread_lane u_lane (
			.clk         (clk),
			.rst_n       (rst_n),
			.issue_valid (issue_valid[i]),
			.issue_op    (issue_op),
			.take        (take[i]),
			.lane_busy   (thread_busy[i]),
			.done        (lane_done[i]),
			.result      (lane_result[i])
		);
	end

	alu_result_merge u_merge (
		.clk        (clk),
		.rst_n      (rst_n),
		.done       (lane_done),
		.result     (lane_result),
		.take       (take),
		.out_valid  (out_valid),
		.out_thread (out_thread),
		.out_y      (out_y),
		.out_zero   (out_zero)
	);

endmodule

// ==== logic/alu_result_merge.sv ====
`include "alu_params.svh"

module alu_result_merge (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [`ALU_NUM_THREADS-1:0]   done,
	input  alu_result_pkg::lane_result_t  result [`ALU_NUM_THREADS],
	output logic [`ALU_NUM_THREADS-1:0]   take,
	output logic                          out_valid,
	output alu_op_pkg::thread_id_t        out_thread,
	output alu_op_pkg::alu_word_t         out_y,
	output logic                          out_zero
);
	import alu_op_pkg::*;
	import alu_result_pkg::*;

	thread_id_t last;       // Last lane served
	thread_id_t grant_id;
	logic       found;

	// Search starts one past the last grant
	always_comb begin
		thread_id_t idx;
		grant_id = last;
		found    = 1'b0;
		for (int i = 1; i <= `ALU_NUM_THREADS; i++) begin
			idx = thread_id_t'(int'(last) + i);
			if (!found && done[idx]) begin
				found    = 1'b1;
				grant_id = idx;
			end
		end
	end

	always_comb begin
		take = '0;
		if (found)
			take[grant_id] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			last      <= thread_id_t'(`ALU_NUM_THREADS - 1);  // Thread 0 first
		end else begin
			out_valid <= found;
			if (found)
				last <= grant_id;
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			out_thread <= grant_id;
			out_y      <= result[grant_id].y;
			out_zero   <= result[grant_id].zero;
		end
	end

endmodule

// ==== logic/alu_thread_lane.sv ====
module alu_thread_lane (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_valid,
	input  alu_op_pkg::alu_issue_t       issue_op,
	input  logic                         take,
	output logic                         lane_busy,
	output logic                         done,
	output alu_result_pkg::lane_result_t result
);
	import alu_op_pkg::*;
	import alu_result_pkg::*;

	lane_state_t state;
	hilo_t       hilo;          // This thread's HI/LO
	hilo_t       core_hilo;
	logic        core_hilo_write;
	alu_word_t   core_y;
	logic        core_zero;
	logic        accept;
	logic        div_start;
	logic        div_busy;
	logic        div_finish;
	alu_word_t   div_quo;
	alu_word_t   div_rem;

	assign accept    = issue_valid && (state == LANE_IDLE);
	assign div_start = accept && issue_op.is_div;
	assign lane_busy = (state != LANE_IDLE) || div_busy;
	assign done      = (state == LANE_DONE);

	alu_core u_core (
		.ctl        (issue_op.ctl),
		.a          (issue_op.a),
		.b          (issue_op.b),
		.hilo       (hilo),
		.y          (core_y),
		.zero       (core_zero),
		.hilo_next  (core_hilo),
		.hilo_write (core_hilo_write)
	);

	alu_divider u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (div_start),
		.is_signed (issue_op.ctl == CTL_DIV),
		.dividend  (issue_op.a),
		.divisor   (issue_op.b),
		.busy      (div_busy),
		.finish    (div_finish),
		.quotient  (div_quo),
		.remainder (div_rem)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= LANE_IDLE;
			hilo  <= '0;
		end else begin
			case (state)
				LANE_IDLE: begin
					if (div_start) begin
						state <= LANE_DIV;
					end else if (accept) begin
						state <= LANE_DONE;
						if (core_hilo_write)
							hilo <= core_hilo;
					end
				end
				LANE_DIV: begin
					if (div_finish) begin
						state <= LANE_DONE;
						hilo  <= '{hi: div_rem, lo: div_quo};
					end
				end
				LANE_DONE: begin
					if (take)
						state <= LANE_IDLE;  // Busy drops on the same edge
				end
				default: state <= LANE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !issue_op.is_div)
			result <= '{y: core_y, zero: core_zero};
		else if ((state == LANE_DIV) && div_finish)
			result <= '{y: '0, zero: 1'b1};  // Divide reports through HI/LO only
	end

endmodule

// ==== logic/alu_divider.sv ====
`include "alu_params.svh"

module alu_divider (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic                  is_signed,
	input  alu_op_pkg::alu_word_t dividend,
	input  alu_op_pkg::alu_word_t divisor,
	output logic                  busy,
	output logic                  finish,
	output alu_op_pkg::alu_word_t quotient,
	output alu_op_pkg::alu_word_t remainder
);
	import alu_op_pkg::*;

	localparam div_cnt_t LAST_STEP = div_cnt_t'(`ALU_DIV_STEPS - 1);

	div_cnt_t               count;
	alu_word_t              rem_q;
	alu_word_t              quo_q;  // Dividend bits shift out, quotient bits shift in
	alu_word_t              dvs_q;
	logic                   neg_quo;
	logic                   neg_rem;
	logic                   div_zero;
	logic [`ALU_DATA_W:0]   rem_sh;
	logic                   fits;
	alu_word_t              rem_next;
	alu_word_t              quo_next;
	logic                   a_neg;
	logic                   b_neg;

	assign a_neg = is_signed && dividend[`ALU_DATA_W-1];
	assign b_neg = is_signed && divisor[`ALU_DATA_W-1];

	// One restoring step on the current registers
	assign rem_sh   = {rem_q, quo_q[`ALU_DATA_W-1]};
	assign fits     = rem_sh >= {1'b0, dvs_q};
	assign rem_next = fits ? alu_word_t'(rem_sh - {1'b0, dvs_q}) : rem_sh[`ALU_DATA_W-1:0];
	assign quo_next = {quo_q[`ALU_DATA_W-2:0], fits};

	assign finish    = busy && (count == LAST_STEP);
	assign quotient  = (neg_quo && !div_zero) ? -quo_next : quo_next;
	assign remainder = neg_rem ? -rem_next : rem_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy  <= 1'b1;
			count <= '0;
		end else if (busy) begin
			count <= count + 1'b1;
			if (count == LAST_STEP)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem_q    <= '0;
			quo_q    <= a_neg ? -dividend : dividend;  // Magnitudes
			dvs_q    <= b_neg ? -divisor : divisor;
			neg_quo  <= a_neg ^ b_neg;
			neg_rem  <= a_neg;
			div_zero <= (divisor == '0);
		end else if (busy) begin
			rem_q <= rem_next;
			quo_q <= quo_next;
		end
	end

endmodule

// ==== logic/alu_core.sv ====
`include "alu_params.svh"

module alu_core (
	input  alu_op_pkg::alu_ctl_t     ctl,
	input  alu_op_pkg::alu_word_t    a,
	input  alu_op_pkg::alu_word_t    b,
	input  alu_result_pkg::hilo_t    hilo,
	output alu_op_pkg::alu_word_t    y,
	output logic                     zero,
	output alu_result_pkg::hilo_t    hilo_next,
	output logic                     hilo_write
);
	import alu_op_pkg::*;
	import alu_result_pkg::*;

	logic [2*`ALU_DATA_W-1:0]        prod_u;
	logic signed [2*`ALU_DATA_W-1:0] prod_s;
	logic [4:0]                      sa_imm;
	logic [4:0]                      sa_var;

	assign sa_imm = b[10:6];  // Shift amount field of the instruction
	assign sa_var = b[4:0];

	assign prod_u = {{`ALU_DATA_W{1'b0}}, a} * {{`ALU_DATA_W{1'b0}}, b};
	assign prod_s = $signed({{`ALU_DATA_W{a[`ALU_DATA_W-1]}}, a})
		* $signed({{`ALU_DATA_W{b[`ALU_DATA_W-1]}}, b});

	always_comb begin
		y          = '0;
		hilo_next  = hilo;
		hilo_write = 1'b0;
		case (ctl)
			CTL_AND:  y = a & b;
			CTL_OR:   y = a | b;
			CTL_XOR:  y = a ^ b;
			CTL_ADDU: y = a + b;
			CTL_SUBU: y = a - b;
			CTL_SLTU: y = alu_word_t'(a < b);
			CTL_SLT:  y = alu_word_t'($signed(a) < $signed(b));
			CTL_MULTU: begin
				hilo_next  = prod_u;
				hilo_write = 1'b1;
			end
			CTL_MULT: begin
				hilo_next  = prod_s;
				hilo_write = 1'b1;
			end
			CTL_SLL:  y = a << sa_imm;
			CTL_SLLV: y = a << sa_var;
			CTL_SRA:  y = $signed(a) >>> sa_imm;
			CTL_SRL:  y = a >> sa_imm;
			CTL_SRAV: y = $signed(a) >>> sa_var;
			CTL_SRLV: y = a >> sa_var;
			CTL_DIV, CTL_DIVU: y = '0;  // Divider owns these
			CTL_MFHI: y = hilo.hi;
			CTL_MFLO: y = hilo.lo;

			// Branch tests give y = 0 when taken
			CTL_BLTZ, CTL_BLTZAL: y = ($signed(a) < 0) ? '0 : alu_word_t'(1);
			CTL_BGTZ: y = ($signed(a) > 0) ? '0 : alu_word_t'(1);
			CTL_BEQ:  y = (a == '0) ? '0 : alu_word_t'(1);
			CTL_BNE:  y = (a != '0) ? '0 : alu_word_t'(1);

			CTL_LUI:  y = b << 16;
			CTL_JR:   y = a;
			default:  y = a & b;
		endcase
	end

	assign zero = (y == '0);

endmodule

// ==== logic/alu_dispatch.sv ====
`include "alu_params.svh"

module alu_dispatch (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         in_valid,
	input  alu_op_pkg::alu_word_t        in_instr,
	input  alu_op_pkg::thread_id_t       in_thread,
	input  alu_op_pkg::alu_word_t        in_rs,
	input  alu_op_pkg::alu_word_t        in_rt,
	input  logic [`ALU_NUM_THREADS-1:0]  lane_busy,
	output logic [`ALU_NUM_THREADS-1:0]  issue_valid,
	output alu_op_pkg::alu_issue_t       issue_op,
	output logic                         in_reject
);
	import alu_op_pkg::*;

	localparam logic [5:0] OP_RTYPE  = 6'h00;
	localparam logic [5:0] OP_REGIMM = 6'h01;
	localparam logic [5:0] OP_BEQ    = 6'h04;
	localparam logic [5:0] OP_BNE    = 6'h05;
	localparam logic [5:0] OP_BGTZ   = 6'h07;
	localparam logic [5:0] OP_LUI    = 6'h0f;

	logic [5:0]                   opcode;
	logic [5:0]                   funct;
	logic [4:0]                   rt_field;
	alu_ctl_t                     ctl;
	alu_word_t                    b_sel;
	logic [`ALU_NUM_THREADS-1:0]  blocked;

	assign opcode   = in_instr[31:26];
	assign funct    = in_instr[5:0];
	assign rt_field = in_instr[20:16];

	// A lane issued last cycle has not raised busy yet
	assign blocked = lane_busy | issue_valid;

	always_comb begin
		ctl = CTL_AND;  // Unknown encodings
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					6'h00: ctl = CTL_SLL;
					6'h02: ctl = CTL_SRL;
					6'h03: ctl = CTL_SRA;
					6'h04: ctl = CTL_SLLV;
					6'h06: ctl = CTL_SRLV;
					6'h07: ctl = CTL_SRAV;
					6'h08: ctl = CTL_JR;
					6'h10: ctl = CTL_MFHI;
					6'h12: ctl = CTL_MFLO;
					6'h18: ctl = CTL_MULT;
					6'h19: ctl = CTL_MULTU;
					6'h1a: ctl = CTL_DIV;
					6'h1b: ctl = CTL_DIVU;
					6'h21: ctl = CTL_ADDU;
					6'h23: ctl = CTL_SUBU;
					6'h24: ctl = CTL_AND;
					6'h25: ctl = CTL_OR;
					6'h26: ctl = CTL_XOR;
					6'h2a: ctl = CTL_SLT;
					6'h2b: ctl = CTL_SLTU;
					default: ctl = CTL_AND;
				endcase
			end
			OP_REGIMM: begin
				if (rt_field == 5'h10)
					ctl = CTL_BLTZAL;
				else if (rt_field == 5'h00)
					ctl = CTL_BLTZ;
			end
			OP_BEQ:  ctl = CTL_BEQ;
			OP_BNE:  ctl = CTL_BNE;
			OP_BGTZ: ctl = CTL_BGTZ;
			OP_LUI:  ctl = CTL_LUI;
			default: ctl = CTL_AND;
		endcase
	end

	always_comb begin
		case (ctl)
			CTL_SLL, CTL_SRL, CTL_SRA: b_sel = in_instr;  // Core reads sa from b[10:6]
			CTL_LUI: b_sel = {{(`ALU_DATA_W-16){1'b0}}, in_instr[15:0]};
			default: b_sel = in_rt;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue_valid <= '0;
			in_reject   <= 1'b0;
		end else begin
			issue_valid <= '0;
			in_reject   <= 1'b0;
			if (in_valid) begin
				if (blocked[in_thread])
					in_reject <= 1'b1;
				else
					issue_valid[in_thread] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			issue_op <= '{ctl: ctl, a: in_rs, b: b_sel,
				is_div: (ctl == CTL_DIV) || (ctl == CTL_DIVU)};
	end

endmodule

// ==== logic/alu_result_pkg.sv ====
package alu_result_pkg;

	// hi sits in the upper half so a 64-bit product maps straight on
	typedef struct packed {
		alu_op_pkg::alu_word_t hi;
		alu_op_pkg::alu_word_t lo;
	} hilo_t;

	typedef struct packed {
		alu_op_pkg::alu_word_t y;
		logic                  zero;
	} lane_result_t;

endpackage

// ==== logic/alu_op_pkg.sv ====
`include "alu_params.svh"

package alu_op_pkg;

	typedef logic [4:0]                          alu_ctl_t;
	typedef logic [`ALU_DATA_W-1:0]              alu_word_t;
	typedef logic [$clog2(`ALU_NUM_THREADS)-1:0] thread_id_t;
	typedef logic [$clog2(`ALU_DIV_STEPS)-1:0]   div_cnt_t;

	localparam alu_ctl_t CTL_AND    = 5'd0;
	localparam alu_ctl_t CTL_OR     = 5'd1;
	localparam alu_ctl_t CTL_XOR    = 5'd2;
	localparam alu_ctl_t CTL_ADDU   = 5'd3;
	localparam alu_ctl_t CTL_SUBU   = 5'd4;
	localparam alu_ctl_t CTL_SLTU   = 5'd5;
	localparam alu_ctl_t CTL_SLT    = 5'd6;
	localparam alu_ctl_t CTL_MULTU  = 5'd7;
	localparam alu_ctl_t CTL_MULT   = 5'd8;
	localparam alu_ctl_t CTL_SLL    = 5'd9;
	localparam alu_ctl_t CTL_SLLV   = 5'd10;
	localparam alu_ctl_t CTL_SRA    = 5'd11;
	localparam alu_ctl_t CTL_SRL    = 5'd12;
	localparam alu_ctl_t CTL_SRAV   = 5'd13;
	localparam alu_ctl_t CTL_SRLV   = 5'd14;
	localparam alu_ctl_t CTL_DIV    = 5'd15;
	localparam alu_ctl_t CTL_DIVU   = 5'd16;
	localparam alu_ctl_t CTL_MFHI   = 5'd17;
	localparam alu_ctl_t CTL_MFLO   = 5'd18;
	localparam alu_ctl_t CTL_BLTZ   = 5'd19;
	localparam alu_ctl_t CTL_BLTZAL = 5'd20;
	localparam alu_ctl_t CTL_BGTZ   = 5'd21;
	localparam alu_ctl_t CTL_BEQ    = 5'd22;  // Compares a against zero
	localparam alu_ctl_t CTL_BNE    = 5'd23;
	localparam alu_ctl_t CTL_LUI    = 5'd24;
	localparam alu_ctl_t CTL_JR     = 5'd25;

	typedef struct packed {
		alu_ctl_t  ctl;
		alu_word_t a;
		alu_word_t b;
		logic      is_div;  // Set by dispatch for DIV and DIVU
	} alu_issue_t;

	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_DIV,
		LANE_DONE
	} lane_state_t;

endpackage

// ==== include/alu_params.svh ====
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Hardware threads, one execute lane each
`define ALU_NUM_THREADS 4

// Operand and result width
`define ALU_DATA_W 32

// One quotient bit per divider iteration
`define ALU_DIV_STEPS 32

`endif
